// File: src/gw_pkg.sv
package gw_pkg;

  // Host side widths
  localparam int data_width_gp        = 32;
  localparam int addr_width_gp        = 8;
  localparam int tag_width_gp         = 4;

  // Wormhole link widths
  localparam int flit_width_gp        = 32;
  localparam int len_width_gp         = 2;

  // Tag payload with bit 0 as the core reset and bit 1 as padding
  localparam int tag_payload_width_gp = 2;

  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } gw_op_e;

  typedef struct packed {
    gw_op_e                   op;
    logic [addr_width_gp-1:0] addr;
    logic [data_width_gp-1:0] data;
    logic [tag_width_gp-1:0]  tag;
  } mc_req_s;

  typedef struct packed {
    gw_op_e                   op;
    logic [data_width_gp-1:0] data;
    logic [tag_width_gp-1:0]  tag;
  } mc_resp_s;

  //////////////////////////////////////////////////
  // Bit offsets of the header flit fields
  //////////////////////////////////////////////////

  // len counts the data flits after the header
  localparam int hdr_len_lsb_gp  = 0;
  localparam int hdr_op_lsb_gp   = hdr_len_lsb_gp + len_width_gp;
  localparam int hdr_tag_lsb_gp  = hdr_op_lsb_gp + 1;
  localparam int hdr_addr_lsb_gp = hdr_tag_lsb_gp + tag_width_gp;

endpackage

// File: src/gw_tag_client.sv
`timescale 1ns/100ps

module gw_tag_client
  import gw_pkg::*;
  (input                                   hb_clk_i
  ,input                                   reset_i
  ,input                                   tag_bit_i
  ,output logic [tag_payload_width_gp-1:0] payload_o
  ,output logic                            new_o
  );

  localparam int cnt_width_lp = $clog2(tag_payload_width_gp + 1);

  logic                            recv_r;
  logic [cnt_width_lp-1:0]         cnt_r;
  logic [tag_payload_width_gp-1:0] shift_r;
  logic [tag_payload_width_gp-1:0] shift_n;
  logic                            last_bit;

  // LSB arrives first, so each new bit enters at the top
  assign shift_n  = (shift_r >> 1)
                  | (tag_payload_width_gp'(tag_bit_i) << (tag_payload_width_gp - 1));
  assign last_bit = recv_r && (cnt_r == cnt_width_lp'(tag_payload_width_gp - 1));

  // Idle until a start bit, then count payload bits
  always_ff @(posedge hb_clk_i) begin
    if (reset_i) begin
      recv_r <= 1'b0;
      cnt_r  <= '0;
    end else if (!recv_r) begin
      recv_r <= tag_bit_i;
      cnt_r  <= '0;
    end else begin
      recv_r <= !last_bit;
      cnt_r  <= cnt_r + 1'b1;
    end
  end

  always_ff @(posedge hb_clk_i) begin
    if (recv_r) begin
      shift_r <= shift_n;
    end
  end

  // Committed payload comes out of reset with the reset bit set
  always_ff @(posedge hb_clk_i) begin
    if (reset_i) begin
      payload_o <= tag_payload_width_gp'(1);
      new_o     <= 1'b0;
    end else begin
      new_o <= last_bit;
      if (last_bit) begin
        payload_o <= shift_n;
      end
    end
  end

endmodule

// File: src/gw_fifo.sv
`timescale 1ns/100ps

module gw_fifo
  #(parameter int  els_p     = 2
   ,parameter type payload_t = logic [31:0]
   )
  (input            clk_i
  ,input            reset_i
  ,input            v_i
  ,input  payload_t data_i
  ,output logic     ready_o
  ,output logic     v_o
  ,output payload_t data_o
  ,input            yumi_i
  );

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_width_lp = $clog2(els_p + 1);

  payload_t                mem_r [els_p];
  logic [ptr_width_lp-1:0] wptr_r;
  logic [ptr_width_lp-1:0] rptr_r;
  logic [cnt_width_lp-1:0] cnt_r;
  logic [cnt_width_lp-1:0] cnt_n;
  logic                    enq;

  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    return (ptr == ptr_width_lp'(els_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign enq    = v_i & ready_o;
  assign cnt_n  = cnt_r + cnt_width_lp'(enq) - cnt_width_lp'(yumi_i);
  assign v_o    = (cnt_r != '0);
  assign data_o = mem_r[rptr_r];

  // Ready is registered so it stays low through reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      cnt_r   <= '0;
      ready_o <= 1'b0;
    end else begin
      cnt_r   <= cnt_n;
      ready_o <= (cnt_n != cnt_width_lp'(els_p));
      if (enq) begin
        wptr_r <= next_ptr(wptr_r);
      end
      if (yumi_i) begin
        rptr_r <= next_ptr(rptr_r);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

endmodule

// File: src/gw_mc_to_wh.sv
`timescale 1ns/100ps

module gw_mc_to_wh
  import gw_pkg::*;
  (input                            hb_clk_i
  ,input                            reset_i
  ,input                            req_v_i
  ,input  mc_req_s                  req_i
  ,output logic                     req_yumi_o
  ,output logic                     flit_v_o
  ,output logic [flit_width_gp-1:0] flit_o
  ,input                            flit_ready_i
  );

  typedef enum logic [1:0] {
    e_idle,
    e_hdr,
    e_data
  } state_e;

  state_e                   state_r;
  mc_req_s                  req_r;
  logic [flit_width_gp-1:0] hdr_flit;
  logic                     flit_sent;

  // One packet in flight at a time
  assign req_yumi_o = (state_r == e_idle) & req_v_i;
  assign flit_v_o   = (state_r == e_hdr) | (state_r == e_data);
  assign flit_sent  = flit_v_o & flit_ready_i;

  always_comb begin
    hdr_flit = '0;
    hdr_flit[hdr_len_lsb_gp +: len_width_gp]   = (req_r.op == op_store) ? len_width_gp'(1) : '0;
    hdr_flit[hdr_op_lsb_gp]                    = req_r.op;
    hdr_flit[hdr_tag_lsb_gp +: tag_width_gp]   = req_r.tag;
    hdr_flit[hdr_addr_lsb_gp +: addr_width_gp] = req_r.addr;
  end

  assign flit_o = (state_r == e_data) ? req_r.data : hdr_flit;

  always_ff @(posedge hb_clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
    end else begin
      case (state_r)
        e_idle: begin
          if (req_v_i) begin
            state_r <= e_hdr;
          end
        end
        e_hdr: begin
          if (flit_sent) begin
            state_r <= (req_r.op == op_store) ? e_data : e_idle;
          end
        end
        e_data: begin
          if (flit_sent) begin
            state_r <= e_idle;
          end
        end
        default: state_r <= e_idle;
      endcase
    end
  end

  always_ff @(posedge hb_clk_i) begin
    if (req_yumi_o) begin
      req_r <= req_i;
    end
  end

endmodule

// File: src/gw_wh_test_mem.sv
`timescale 1ns/100ps

module gw_wh_test_mem
  import gw_pkg::*;
  #(parameter int mem_words_p = 256)
  (input                            hb_clk_i
  ,input                            reset_i
  ,input                            flit_v_i
  ,input        [flit_width_gp-1:0] flit_i
  ,output logic                     flit_ready_o
  ,output logic                     flit_v_o
  ,output logic [flit_width_gp-1:0] flit_o
  ,input                            flit_ready_i
  );

  localparam int idx_width_lp = $clog2(mem_words_p);

  typedef enum logic [1:0] {
    e_recv_hdr,
    e_recv_data,
    e_reply_hdr,
    e_reply_data
  } state_e;

  state_e                   state_r;
  logic [data_width_gp-1:0] mem_r [mem_words_p];
  gw_op_e                   op_r;
  logic [tag_width_gp-1:0]  tag_r;
  logic [idx_width_lp-1:0]  idx_r;
  logic [data_width_gp-1:0] rdata_r;
  logic [len_width_gp-1:0]  in_len;
  logic [idx_width_lp-1:0]  in_idx;
  logic                     hdr_done;
  logic                     data_done;
  logic                     out_sent;
  logic [flit_width_gp-1:0] rsp_hdr;

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  assign in_len = flit_i[hdr_len_lsb_gp +: len_width_gp];
  assign in_idx = flit_i[hdr_addr_lsb_gp +: idx_width_lp];

  // No new request while a response is pending
  assign flit_ready_o = (state_r == e_recv_hdr) | (state_r == e_recv_data);
  assign hdr_done     = flit_v_i & (state_r == e_recv_hdr);
  assign data_done    = flit_v_i & (state_r == e_recv_data);

  // Execute on the edge of the last request flit
  always_ff @(posedge hb_clk_i) begin
    if (hdr_done) begin
      op_r    <= gw_op_e'(flit_i[hdr_op_lsb_gp]);
      tag_r   <= flit_i[hdr_tag_lsb_gp +: tag_width_gp];
      idx_r   <= in_idx;
      rdata_r <= mem_r[in_idx];
    end
    if (data_done && (op_r == op_store)) begin
      mem_r[idx_r] <= flit_i[data_width_gp-1:0];
    end
  end

  //////////////////////////////////////////////////
  // Reply side
  //////////////////////////////////////////////////

  always_comb begin
    rsp_hdr = '0;
    rsp_hdr[hdr_len_lsb_gp +: len_width_gp] = (op_r == op_load) ? len_width_gp'(1) : '0;
    rsp_hdr[hdr_op_lsb_gp]                  = op_r;
    rsp_hdr[hdr_tag_lsb_gp +: tag_width_gp] = tag_r;
  end

  assign flit_v_o = (state_r == e_reply_hdr) | (state_r == e_reply_data);
  assign flit_o   = (state_r == e_reply_data) ? rdata_r : rsp_hdr;
  assign out_sent = flit_v_o & flit_ready_i;

  always_ff @(posedge hb_clk_i) begin
    if (reset_i) begin
      state_r <= e_recv_hdr;
    end else begin
      case (state_r)
        e_recv_hdr: begin
          if (hdr_done) begin
            state_r <= (in_len != '0) ? e_recv_data : e_reply_hdr;
          end
        end
        e_recv_data: begin
          if (data_done) begin
            state_r <= e_reply_hdr;
          end
        end
        e_reply_hdr: begin
          if (out_sent) begin
            state_r <= (op_r == op_load) ? e_reply_data : e_recv_hdr;
          end
        end
        default: begin
          if (out_sent) begin
            state_r <= e_recv_hdr;
          end
        end
      endcase
    end
  end

endmodule

// File: src/gw_wh_to_mc.sv
`timescale 1ns/100ps

module gw_wh_to_mc
  import gw_pkg::*;
  (input                            hb_clk_i
  ,input                            reset_i
  ,input                            flit_v_i
  ,input        [flit_width_gp-1:0] flit_i
  ,output logic                     flit_ready_o
  ,output logic                     resp_v_o
  ,output mc_resp_s                 resp_o
  ,input                            resp_ready_i
  );

  typedef enum logic [1:0] {
    e_hdr,
    e_data,
    e_resp
  } state_e;

  state_e                   state_r;
  gw_op_e                   op_r;
  logic [tag_width_gp-1:0]  tag_r;
  logic [data_width_gp-1:0] data_r;
  logic                     hdr_done;
  logic                     data_done;

  // Stall the link until the assembled response leaves
  assign flit_ready_o = (state_r != e_resp);
  assign hdr_done     = flit_v_i & (state_r == e_hdr);
  assign data_done    = flit_v_i & (state_r == e_data);

  assign resp_v_o = (state_r == e_resp);
  assign resp_o   = '{op: op_r, data: data_r, tag: tag_r};

  always_ff @(posedge hb_clk_i) begin
    if (reset_i) begin
      state_r <= e_hdr;
    end else begin
      case (state_r)
        e_hdr: begin
          if (hdr_done) begin
            state_r <= (flit_i[hdr_len_lsb_gp +: len_width_gp] != '0) ? e_data : e_resp;
          end
        end
        e_data: begin
          if (data_done) begin
            state_r <= e_resp;
          end
        end
        default: begin
          if (resp_ready_i) begin
            state_r <= e_hdr;
          end
        end
      endcase
    end
  end

  // Store acks carry zero data
  always_ff @(posedge hb_clk_i) begin
    if (hdr_done) begin
      op_r   <= gw_op_e'(flit_i[hdr_op_lsb_gp]);
      tag_r  <= flit_i[hdr_tag_lsb_gp +: tag_width_gp];
      data_r <= '0;
    end else if (data_done) begin
      data_r <= flit_i[data_width_gp-1:0];
    end
  end

endmodule

// File: src/gw_core_complex.sv
`timescale 1ns/100ps

module gw_core_complex
  import gw_pkg::*;
  (input                            hb_clk_i
  ,input                            reset_i
  ,input                            tag_bit_i
  ,input                            tag_trace_done_i

  ,input                            req_v_i
  ,input  gw_op_e                   req_op_i
  ,input        [addr_width_gp-1:0] req_addr_i
  ,input        [data_width_gp-1:0] req_data_i
  ,input        [tag_width_gp-1:0]  req_tag_i
  ,output logic                     req_ready_o

  ,output logic                     resp_v_o
  ,output gw_op_e                   resp_op_o
  ,output logic [data_width_gp-1:0] resp_data_o
  ,output logic [tag_width_gp-1:0]  resp_tag_o
  ,input                            resp_ready_i
  );

  localparam int mem_words_lp = 2 ** addr_width_gp;

  logic [tag_payload_width_gp-1:0] tag_payload_lo;
  logic                            core_reset;

  mc_req_s                  req_li;
  mc_req_s                  req_fifo_lo;
  logic                     req_fifo_v_lo;
  logic                     req_yumi_lo;

  logic                     rq_flit_v;
  logic [flit_width_gp-1:0] rq_flit;
  logic                     rq_flit_ready;
  logic                     rs_flit_v;
  logic [flit_width_gp-1:0] rs_flit;
  logic                     rs_flit_ready;

  mc_resp_s                 resp_li;
  logic                     resp_v_li;
  logic                     resp_ready_lo;
  mc_resp_s                 resp_lo;

  //////////////////////////////////////////////////
  // Tag client and core reset
  //////////////////////////////////////////////////

  gw_tag_client i_tag_client
    (.hb_clk_i  (hb_clk_i)
    ,.reset_i   (reset_i)
    ,.tag_bit_i (tag_bit_i)
    ,.payload_o (tag_payload_lo)
    ,.new_o     ()
    );

  assign core_reset = reset_i | tag_payload_lo[0] | ~tag_trace_done_i;

  //////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////

  assign req_li = '{op: req_op_i, addr: req_addr_i, data: req_data_i, tag: req_tag_i};

  gw_fifo #(.els_p(2), .payload_t(mc_req_s)) i_req_fifo
    (.clk_i   (hb_clk_i)
    ,.reset_i (core_reset)
    ,.v_i     (req_v_i)
    ,.data_i  (req_li)
    ,.ready_o (req_ready_o)
    ,.v_o     (req_fifo_v_lo)
    ,.data_o  (req_fifo_lo)
    ,.yumi_i  (req_yumi_lo)
    );

  gw_mc_to_wh i_mc_to_wh
    (.hb_clk_i     (hb_clk_i)
    ,.reset_i      (core_reset)
    ,.req_v_i      (req_fifo_v_lo)
    ,.req_i        (req_fifo_lo)
    ,.req_yumi_o   (req_yumi_lo)
    ,.flit_v_o     (rq_flit_v)
    ,.flit_o       (rq_flit)
    ,.flit_ready_i (rq_flit_ready)
    );

  gw_wh_test_mem #(.mem_words_p(mem_words_lp)) i_test_mem
    (.hb_clk_i     (hb_clk_i)
    ,.reset_i      (core_reset)
    ,.flit_v_i     (rq_flit_v)
    ,.flit_i       (rq_flit)
    ,.flit_ready_o (rq_flit_ready)
    ,.flit_v_o     (rs_flit_v)
    ,.flit_o       (rs_flit)
    ,.flit_ready_i (rs_flit_ready)
    );

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  gw_wh_to_mc i_wh_to_mc
    (.hb_clk_i     (hb_clk_i)
    ,.reset_i      (core_reset)
    ,.flit_v_i     (rs_flit_v)
    ,.flit_i       (rs_flit)
    ,.flit_ready_o (rs_flit_ready)
    ,.resp_v_o     (resp_v_li)
    ,.resp_o       (resp_li)
    ,.resp_ready_i (resp_ready_lo)
    );

  gw_fifo #(.els_p(2), .payload_t(mc_resp_s)) i_resp_fifo
    (.clk_i   (hb_clk_i)
    ,.reset_i (core_reset)
    ,.v_i     (resp_v_li)
    ,.data_i  (resp_li)
    ,.ready_o (resp_ready_lo)
    ,.v_o     (resp_v_o)
    ,.data_o  (resp_lo)
    ,.yumi_i  (resp_v_o & resp_ready_i)
    );

  assign resp_op_o   = resp_lo.op;
  assign resp_data_o = resp_lo.data;
  assign resp_tag_o  = resp_lo.tag;

endmodule

// File: dv/gw_checker.sv
`timescale 1ns/100ps

module gw_checker
  import gw_pkg::*;
  (input                      hb_clk_i
  ,input                      req_v_i
  ,input gw_op_e              req_op_i
  ,input [addr_width_gp-1:0]  req_addr_i
  ,input [data_width_gp-1:0]  req_data_i
  ,input [tag_width_gp-1:0]   req_tag_i
  ,input                      req_ready_i
  ,input                      resp_v_i
  ,input gw_op_e              resp_op_i
  ,input [data_width_gp-1:0]  resp_data_i
  ,input [tag_width_gp-1:0]   resp_tag_i
  ,input                      resp_ready_i
  ,input                      held_i
  ,input                      final_i
  ,output int                 req_cnt_o
  ,output int                 resp_cnt_o
  ,output int                 err_cnt_o
  ,output int                 pending_o
  );

  logic [data_width_gp-1:0] mem_model [2**addr_width_gp];
  mc_resp_s                 exp_q [$];
  int                       req_cnt = 0;
  int                       resp_cnt = 0;
  int                       err_cnt = 0;
  int                       pending = 0;
  logic                     final_done = 1'b0;

  assign req_cnt_o  = req_cnt;
  assign resp_cnt_o = resp_cnt;
  assign err_cnt_o  = err_cnt;
  assign pending_o  = pending;

  task automatic check_field(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got_val);
    if (got_val !== exp_val) begin
      $display("error: time %0t signal %s expected %h got %h", $time, name, exp_val, got_val);
      err_cnt++;
    end
  endtask

  always @(posedge hb_clk_i) begin
    mc_resp_s exp_resp;
    // Expected response is fixed when the request is accepted
    if (req_v_i && req_ready_i) begin
      if (req_op_i == op_store) begin
        mem_model[req_addr_i] = req_data_i;
        exp_resp = '{op: op_store, data: '0, tag: req_tag_i};
      end else begin
        exp_resp = '{op: op_load, data: mem_model[req_addr_i], tag: req_tag_i};
      end
      exp_q.push_back(exp_resp);
      req_cnt++;
    end
    if (resp_v_i && resp_ready_i) begin
      resp_cnt++;
      if (exp_q.size() == 0) begin
        $display("error: time %0t a response with tag %h came with no request outstanding",
                 $time, resp_tag_i);
        err_cnt++;
      end else begin
        exp_resp = exp_q.pop_front();
        check_field("resp_op_o", 32'(exp_resp.op), 32'(resp_op_i));
        check_field("resp_tag_o", 32'(exp_resp.tag), 32'(resp_tag_i));
        check_field("resp_data_o", exp_resp.data, resp_data_i);
      end
    end
    pending = exp_q.size();
    // Core held in reset
    if (held_i) begin
      check_field("req_ready_o", 32'b0, 32'(req_ready_i));
      check_field("resp_v_o", 32'b0, 32'(resp_v_i));
    end
    if (final_i && !final_done) begin
      final_done = 1'b1;
      if (exp_q.size() != 0) begin
        $display("error: time %0t %0d expected responses never arrived", $time, exp_q.size());
        err_cnt++;
      end
    end
  end

endmodule

// File: dv/gw_tb.sv
`timescale 1ns/100ps

module gw_tb
  import gw_pkg::*;
  ();

  localparam int num_reqs_lp       = 400;
  localparam int work_set_lp       = 8;
  localparam int drain_limit_lp    = 500;
  localparam int timeout_cycles_lp = num_reqs_lp * 40 + 2000;

  logic                     hb_clk;
  logic                     reset;
  logic                     tag_bit;
  logic                     tag_trace_done;
  logic                     req_v;
  gw_op_e                   req_op;
  logic [addr_width_gp-1:0] req_addr;
  logic [data_width_gp-1:0] req_data;
  logic [tag_width_gp-1:0]  req_tag;
  logic                     req_ready;
  logic                     resp_v;
  gw_op_e                   resp_op;
  logic [data_width_gp-1:0] resp_data;
  logic [tag_width_gp-1:0]  resp_tag;
  logic                     resp_ready;
  logic                     held;
  logic                     final_check;
  int                       req_cnt;
  int                       resp_cnt;
  int                       err_cnt;
  int                       pending;
  logic [addr_width_gp-1:0] work_addr [work_set_lp];
  logic                     stored [work_set_lp];

  gw_core_complex i_dut
    (.hb_clk_i         (hb_clk)
    ,.reset_i          (reset)
    ,.tag_bit_i        (tag_bit)
    ,.tag_trace_done_i (tag_trace_done)
    ,.req_v_i          (req_v)
    ,.req_op_i         (req_op)
    ,.req_addr_i       (req_addr)
    ,.req_data_i       (req_data)
    ,.req_tag_i        (req_tag)
    ,.req_ready_o      (req_ready)
    ,.resp_v_o         (resp_v)
    ,.resp_op_o        (resp_op)
    ,.resp_data_o      (resp_data)
    ,.resp_tag_o       (resp_tag)
    ,.resp_ready_i     (resp_ready)
    );

  gw_checker i_checker
    (.hb_clk_i     (hb_clk)
    ,.req_v_i      (req_v)
    ,.req_op_i     (req_op)
    ,.req_addr_i   (req_addr)
    ,.req_data_i   (req_data)
    ,.req_tag_i    (req_tag)
    ,.req_ready_i  (req_ready)
    ,.resp_v_i     (resp_v)
    ,.resp_op_i    (resp_op)
    ,.resp_data_i  (resp_data)
    ,.resp_tag_i   (resp_tag)
    ,.resp_ready_i (resp_ready)
    ,.held_i       (held)
    ,.final_i      (final_check)
    ,.req_cnt_o    (req_cnt)
    ,.resp_cnt_o   (resp_cnt)
    ,.err_cnt_o    (err_cnt)
    ,.pending_o    (pending)
    );

  always #10 hb_clk = ~hb_clk;

  // Host accepts responses about 70 percent of the time
  always @(negedge hb_clk) begin
    resp_ready = (($urandom % 10) >= 3);
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  task automatic send_frame(input logic [tag_payload_width_gp-1:0] payload);
    tag_bit = 1'b1;
    @(negedge hb_clk);
    for (int i = 0; i < tag_payload_width_gp; i++) begin
      tag_bit = payload[i];
      @(negedge hb_clk);
    end
    tag_bit = 1'b0;
  endtask

  // Ready is registered, so its value at the falling edge decides the transfer
  task automatic send_req(input gw_op_e op, input logic [addr_width_gp-1:0] addr,
                          input logic [data_width_gp-1:0] data,
                          input logic [tag_width_gp-1:0] tag);
    req_v    = 1'b1;
    req_op   = op;
    req_addr = addr;
    req_data = data;
    req_tag  = tag;
    while (!req_ready) begin
      @(negedge hb_clk);
    end
    @(negedge hb_clk);
    req_v = 1'b0;
  endtask

  task automatic wait_ready();
    while (!req_ready) begin
      @(negedge hb_clk);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((pending != 0) && (waited < drain_limit_lp)) begin
      @(negedge hb_clk);
      waited++;
    end
  endtask

  task automatic check_held(input int cycles);
    repeat (2) @(negedge hb_clk);
    held = 1'b1;
    repeat (cycles) @(negedge hb_clk);
    held = 1'b0;
  endtask

  task automatic random_traffic();
    int     idx;
    gw_op_e op;
    for (int i = 0; i < num_reqs_lp; i++) begin
      idx = int'($urandom % work_set_lp);
      // Loads only go to words already written
      op  = (!stored[idx] || ($urandom % 2 == 0)) ? op_store : op_load;
      send_req(op, work_addr[idx], $urandom, tag_width_gp'($urandom));
      if (op == op_store) begin
        stored[idx] = 1'b1;
      end
      if ($urandom % 4 == 0) begin
        @(negedge hb_clk);
      end
    end
  endtask

  task automatic load_stored();
    for (int i = 0; i < work_set_lp; i++) begin
      if (stored[i]) begin
        send_req(op_load, work_addr[i], '0, tag_width_gp'(i));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(83));
    hb_clk         = 1'b0;
    reset          = 1'b1;
    tag_bit        = 1'b0;
    tag_trace_done = 1'b1;
    req_v          = 1'b0;
    req_op         = op_load;
    req_addr       = '0;
    req_data       = '0;
    req_tag        = '0;
    resp_ready     = 1'b1;
    held           = 1'b0;
    final_check    = 1'b0;
    for (int i = 0; i < work_set_lp; i++) begin
      work_addr[i] = addr_width_gp'($urandom);
      stored[i]    = 1'b0;
    end
    repeat (8) @(negedge hb_clk);
    reset = 1'b0;

    // Tag reset bit still set after reset
    check_held(20);
    send_frame(2'b00);
    wait_ready();

    send_req(op_store, work_addr[0], 32'ha5c3_1e07, 4'h3);
    stored[0] = 1'b1;
    send_req(op_load, work_addr[0], '0, 4'h9);
    drain();

    random_traffic();
    drain();

    // Core reset through the tag line keeps the memory words
    send_frame(2'b01);
    check_held(20);
    send_frame(2'b00);
    wait_ready();
    load_stored();
    drain();

    // Trace not done overrides a clear payload
    tag_trace_done = 1'b0;
    check_held(20);
    tag_trace_done = 1'b1;
    wait_ready();
    load_stored();
    drain();

    final_check = 1'b1;
    repeat (2) @(negedge hb_clk);
    $display("requests %0d responses %0d errors %0d", req_cnt, resp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    repeat (timeout_cycles_lp) @(posedge hb_clk);
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: vlog.f
src/gw_pkg.sv
src/gw_tag_client.sv
src/gw_fifo.sv
src/gw_mc_to_wh.sv
src/gw_wh_test_mem.sv
src/gw_wh_to_mc.sv
src/gw_core_complex.sv
dv/gw_checker.sv
dv/gw_tb.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module gw_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vgw_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
